//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --timescale 1ns/1ps
TOP = tb_zx_ula
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- compile.f
src/ula_timing_pkg.sv
src/ula_bus_pkg.sv
src/raster_gen.sv
src/screen_fetch.sv
src/port_regs.sv
src/mem_map.sv
src/zx_ula.sv
test/tb_zx_ula.sv

//--- src/mem_map.sv
`timescale 1ns/1ps
`default_nettype none

module mem_map
	import ula_bus_pkg::*;
(
	input wire clk14,
	input wire rst_n,
	input wire [15:14] addr,
	input wire n_mreq,
	input wire [PAGE_W-1:0] ram_bank,
	input wire rom_bank,
	output logic n_romcs,
	output logic n_ramcs,
	output logic [PAGE_W-1:0] ram_page,
	output logic rom_page
);

	wire rom_region = addr == 2'b00;
	logic [PAGE_W-1:0] page_sel;

	// 0000-3FFF rom, 4000 and 8000 fixed, C000 paged by 7FFD
	always_comb begin
		case (addr)
			2'b01: page_sel = BANK_AT_4000;
			2'b10: page_sel = BANK_AT_8000;
			2'b11: page_sel = ram_bank;
			default: page_sel = '0;
		endcase
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			n_romcs <= 1'b1;
			n_ramcs <= 1'b1;
			ram_page <= '0;
			rom_page <= 1'b0;
		end else begin
			n_romcs <= !(!n_mreq && rom_region);
			n_ramcs <= !(!n_mreq && !rom_region);
			ram_page <= page_sel;
			rom_page <= rom_bank;
		end
	end

endmodule

`default_nettype wire

//--- src/port_regs.sv
`timescale 1ns/1ps
`default_nettype none

module port_regs
	import ula_bus_pkg::*;
(
	input wire clk14,
	input wire rst_n,
	input wire [15:0] addr,
	input wire [7:0] d_in,
	input wire n_rd,
	input wire n_wr,
	input wire n_iorq,
	input wire n_m1,
	input wire [4:0] kd,
	input wire tape_in,
	output logic [7:0] d_out,
	output logic d_out_en,
	output logic [2:0] border,
	output logic beeper,
	output logic tape_out,
	output logic [2:0] ram_bank,
	output logic vbank,
	output logic rom_bank,
	output logic timings
);

	// only the low five bits of FE and six of 7FFD do anything
	logic [4:0] fe_reg;
	logic [5:0] p7ffd_reg;

	// I/O cycle, interrupt acknowledge excluded
	wire io_cycle = !n_iorq && n_m1;

	wire fe_sel = io_cycle && !addr[0];
	wire p7ffd_sel = io_cycle && !addr[1] && !addr[15] && (addr[14] || addr[13]);
	wire cfg_sel = io_cycle && addr[0] && addr[1];

	wire lock = p7ffd_reg[P7FFD_LOCK];
	wire fe_read = fe_sel && !n_rd;

	// keyboard and tape in, unused bits read high
	wire [7:0] fe_data = {1'b1, tape_in, 1'b1, kd};

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			fe_reg <= '0;
			p7ffd_reg <= '0;
			timings <= 1'b0;
		end else begin
			if (fe_sel && !n_wr)
				fe_reg <= d_in[4:0];
			// paging freezes once the lock bit is written
			if (p7ffd_sel && !n_wr && !lock)
				p7ffd_reg <= d_in[5:0];
			if (cfg_sel && !n_wr && addr[CFG_TIMINGS_ABIT])
				timings <= d_in[0];
		end
	end

	// read data comes out one cycle after the decode
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			d_out <= '0;
			d_out_en <= 1'b0;
		end else begin
			d_out_en <= fe_read;
			d_out <= fe_read ? fe_data : 8'h00;
		end
	end

	assign border = fe_reg[2:0];
	assign beeper = fe_reg[FE_BEEPER];
	// tape out mixes in the tape input, as on the real board
	assign tape_out = fe_reg[FE_TAPE] ^ tape_in;

	assign ram_bank = p7ffd_reg[PAGE_W-1:0];
	assign vbank = p7ffd_reg[P7FFD_VBANK];
	assign rom_bank = p7ffd_reg[P7FFD_ROM];

endmodule

`default_nettype wire

//--- src/raster_gen.sv
`timescale 1ns/1ps
`default_nettype none

module raster_gen
	import ula_timing_pkg::*;
(
	input wire clk14,
	input wire rst_n,
	input wire timings,
	output logic [HC_W-1:0] hc,
	output logic [VC_W-1:0] vc,
	output logic half,
	output logic hsync,
	output logic vsync,
	output logic csync,
	output logic blank,
	output logic n_int
);

	// half-pixel counter, one step per clk14
	logic [HC_W:0] hc0;
	int h;
	int v;
	int h_total;
	int v_total;
	int h_rb;
	int h_b1;
	int h_sync;
	int h_b2;
	int v_bb;
	int v_sync;
	int int_v;
	int int_from;
	int int_to;

	assign hc = hc0[HC_W:1];
	assign half = hc0[0];
	assign h = int'(hc);
	assign v = int'(vc);

	// geometry of the selected mode, timings 1 is 128K
	assign h_total = timings ? H_TOTAL_S128 : H_TOTAL_PENT;
	assign v_total = timings ? V_TOTAL_S128 : V_TOTAL_PENT;
	assign h_rb = timings ? H_RBORDER_S128 : H_RBORDER_PENT;
	assign h_b1 = timings ? H_BLANK1_S128 : H_BLANK1_PENT;
	assign h_sync = timings ? H_SYNC_S128 : H_SYNC_PENT;
	assign h_b2 = timings ? H_BLANK2_S128 : H_BLANK2_PENT;
	assign v_bb = timings ? V_BBORDER_S128 : V_BBORDER_PENT;
	assign v_sync = timings ? V_SYNC_S128 : V_SYNC_PENT;
	assign int_v = timings ? INT_V_S128 : INT_V_PENT;
	assign int_from = timings ? INT_H_FROM_S128 : INT_H_FROM_PENT;
	assign int_to = timings ? INT_H_TO_S128 : INT_H_TO_PENT;

	wire line_end = int'(hc0) >= 2 * h_total - 1;
	wire frame_end = v >= v_total - 1;

	wire hsync0 = h >= H_AREA + h_rb + h_b1 && h < H_AREA + h_rb + h_b1 + h_sync;
	wire vsync0 = v >= V_AREA + v_bb && v < V_AREA + v_bb + v_sync;
	wire hblank0 = h >= H_AREA + h_rb && h < H_AREA + h_rb + h_b1 + h_sync + h_b2;
	wire int0 = v == int_v && h >= int_from && h < int_to;

	// >= on the wrap so a mode switch mid-frame cannot run away
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hc0 <= '0;
			vc <= '0;
		end else if (line_end) begin
			hc0 <= '0;
			if (frame_end)
				vc <= '0;
			else
				vc <= vc + 1'b1;
		end else begin
			hc0 <= hc0 + 1'b1;
		end
	end

	// sync and blank change once per pixel, on the odd half
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b0;
			blank <= 1'b0;
			n_int <= 1'b1;
		end else begin
			if (half) begin
				hsync <= hsync0;
				vsync <= vsync0;
				csync <= hsync0 ^ vsync0;
				blank <= vsync0 || hblank0;
			end
			n_int <= !int0;
		end
	end

endmodule

`default_nettype wire

//--- src/screen_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module screen_fetch
	import ula_timing_pkg::*;
	import ula_bus_pkg::*;
(
	input wire clk14,
	input wire rst_n,
	input wire [HC_W-1:0] hc,
	input wire [VC_W-1:0] vc,
	input wire half,
	input wire blank,
	input wire n_int,
	input wire vbank,
	input wire [2:0] border,
	input wire [7:0] vram_data,
	output logic vram_rd,
	output logic [SCREEN_AW-1:0] vram_addr,
	output colour_t colour
);

	int h;
	int v;
	logic [7:0] attr_next;
	logic [7:0] bitmap_next;
	logic [7:0] attr;
	logic [7:0] bitmap;
	logic [BLINK_W-1:0] blink_cnt;
	logic n_int_q;
	logic [PAGE_W-1:0] screen_bank;

	assign h = int'(hc);
	assign v = int'(vc);

	wire in_rows = v < V_AREA;
	wire fetch_area = in_rows && h < H_AREA;
	// strobes land on half-pixels 2 (attribute) and 3 (bitmap) of each group
	wire attr_issue = fetch_area && hc[2:0] == 3'd0 && half;
	wire bitmap_issue = fetch_area && hc[2:0] == 3'd1 && !half;
	// next bytes go to the shifter on the last half-pixel of the group
	wire load = fetch_area && hc[2:0] == 3'd7 && half;
	wire show = in_rows && h >= SCREEN_DELAY && h < H_AREA + SCREEN_DELAY;
	wire blink = blink_cnt[BLINK_W-1];

	// banks 5 and 7 differ only in bit 1, which is the video page bit
	assign screen_bank = vbank ? BANK_SCREEN_ALT : BANK_SCREEN;

	wire [12:0] bitmap_addr = {vc[7:6], vc[2:0], vc[5:3], hc[7:3]};
	wire [12:0] attr_addr = {3'b110, vc[7:3], hc[7:3]};

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			vram_rd <= 1'b0;
			vram_addr <= '0;
		end else begin
			vram_rd <= attr_issue || bitmap_issue;
			if (attr_issue)
				vram_addr <= {screen_bank[1], attr_addr};
			else if (bitmap_issue)
				vram_addr <= {screen_bank[1], bitmap_addr};
		end
	end

	// attribute answer comes back on the even half and bitmap on the odd one
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			attr_next <= '0;
			bitmap_next <= '0;
			attr <= '0;
			bitmap <= '0;
		end else begin
			if (vram_rd && !half)
				attr_next <= vram_data;
			if (vram_rd && half)
				bitmap_next <= vram_data;
			if (load) begin
				attr <= attr_next;
				bitmap <= bitmap_next;
			end else if (half) begin
				bitmap <= {bitmap[6:0], 1'b0};
			end
		end
	end

	// flash phase counts frame interrupts
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			n_int_q <= 1'b1;
			blink_cnt <= '0;
		end else begin
			n_int_q <= n_int;
			if (n_int_q && !n_int)
				blink_cnt <= blink_cnt + 1'b1;
		end
	end

	wire lit = bitmap[7] ^ (attr[7] & blink);
	wire [2:0] grb = lit ? attr[2:0] : attr[5:3];

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			colour <= '0;
		end else if (half) begin
			if (blank)
				colour <= '0;
			else if (!show)
				colour <= colour_t'({1'b0, border});
			else
				colour <= colour_t'({attr[6] & (|grb), grb});
		end
	end

endmodule

`default_nettype wire

//--- src/ula_bus_pkg.sv
`default_nettype none

package ula_bus_pkg;

	// one video pixel, bright bit on top, then grb as in the attribute
	typedef struct packed {
		logic i;
		logic g;
		logic r;
		logic b;
	} colour_t;

	localparam int PAGE_W = 3;
	// 13-bit screen offset plus the video page bit
	localparam int SCREEN_AW = 14;

	// RAM banks with a fixed role
	localparam logic [PAGE_W-1:0] BANK_SCREEN = 3'd5;
	localparam logic [PAGE_W-1:0] BANK_SCREEN_ALT = 3'd7;
	localparam logic [PAGE_W-1:0] BANK_AT_4000 = 3'd5;
	localparam logic [PAGE_W-1:0] BANK_AT_8000 = 3'd2;

	// port FE bits, border sits in 2..0
	localparam int FE_BEEPER = 4;
	localparam int FE_TAPE = 3;

	// port 7FFD bits, RAM page sits in 2..0
	localparam int P7FFD_VBANK = 3;
	localparam int P7FFD_ROM = 4;
	localparam int P7FFD_LOCK = 5;

	localparam int CFG_TIMINGS_ABIT = 14;

endpackage

`default_nettype wire

//--- src/ula_timing_pkg.sv
`default_nettype none

package ula_timing_pkg;

	// visible screen, in pixels and lines
	localparam int H_AREA = 256;
	localparam int V_AREA = 192;

	// pixels between the byte fetch and the pixel on screen
	localparam int SCREEN_DELAY = 8;

	localparam int H_TOTAL_S128 = 456;
	localparam int V_TOTAL_S128 = 311;
	localparam int H_TOTAL_PENT = 448;
	localparam int V_TOTAL_PENT = 320;

	// 128K line layout after the display area
	localparam int H_RBORDER_S128 = 60 + SCREEN_DELAY;
	localparam int H_BLANK1_S128 = 16;
	localparam int H_SYNC_S128 = 33;
	localparam int H_BLANK2_S128 = 27;
	localparam int V_BBORDER_S128 = 47;
	localparam int V_SYNC_S128 = 8;

	// pentagon line layout after the display area
	localparam int H_RBORDER_PENT = 56 + SCREEN_DELAY;
	localparam int H_BLANK1_PENT = 8;
	localparam int H_SYNC_PENT = 33;
	localparam int H_BLANK2_PENT = 31;
	localparam int V_BBORDER_PENT = 56;
	localparam int V_SYNC_PENT = 8;

	// frame interrupt position, line and pixel window
	localparam int INT_V_S128 = 248;
	localparam int INT_H_FROM_S128 = 0;
	localparam int INT_H_TO_S128 = 64;
	localparam int INT_V_PENT = 239;
	// 64 pixels wide, same pulse length as the 128K frame
	localparam int INT_H_FROM_PENT = 320;
	localparam int INT_H_TO_PENT = 384;

	// counter widths
	localparam int HC_W = 9;
	localparam int VC_W = 9;

	// frame counter for flash, top bit toggles every 16 frames
	localparam int BLINK_W = 5;

endpackage

`default_nettype wire

//--- src/zx_ula.sv
`timescale 1ns/1ps
`default_nettype none

module zx_ula
	import ula_timing_pkg::*;
	import ula_bus_pkg::*;
(
	input wire clk14,
	input wire rst_n,
	// CPU bus
	input wire [15:0] addr,
	input wire [7:0] d_in,
	input wire n_rd,
	input wire n_wr,
	input wire n_mreq,
	input wire n_iorq,
	input wire n_m1,
	output logic [7:0] d_out,
	output logic d_out_en,
	// keyboard and tape
	input wire [4:0] kd,
	input wire tape_in,
	// video memory read port
	output logic vram_rd,
	output logic [SCREEN_AW-1:0] vram_addr,
	input wire [7:0] vram_data,
	// memory map
	output logic n_romcs,
	output logic n_ramcs,
	output logic [PAGE_W-1:0] ram_page,
	output logic rom_page,
	// video out
	output colour_t colour,
	output logic hsync,
	output logic vsync,
	output logic csync,
	output logic n_int,
	output logic beeper,
	output logic tape_out
);

	logic [HC_W-1:0] hc;
	logic [VC_W-1:0] vc;
	logic half;
	logic blank;
	logic timings;
	logic [2:0] border;
	logic [PAGE_W-1:0] ram_bank;
	logic vbank;
	logic rom_bank;

	raster_gen u_raster (
		.clk14(clk14), .rst_n(rst_n), .timings(timings),
		.hc(hc), .vc(vc), .half(half),
		.hsync(hsync), .vsync(vsync), .csync(csync),
		.blank(blank), .n_int(n_int)
	);

	screen_fetch u_fetch (
		.clk14(clk14), .rst_n(rst_n),
		.hc(hc), .vc(vc), .half(half), .blank(blank), .n_int(n_int),
		.vbank(vbank), .border(border), .vram_data(vram_data),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .colour(colour)
	);

	port_regs u_ports (
		.clk14(clk14), .rst_n(rst_n),
		.addr(addr), .d_in(d_in), .n_rd(n_rd), .n_wr(n_wr),
		.n_iorq(n_iorq), .n_m1(n_m1), .kd(kd), .tape_in(tape_in),
		.d_out(d_out), .d_out_en(d_out_en),
		.border(border), .beeper(beeper), .tape_out(tape_out),
		.ram_bank(ram_bank), .vbank(vbank), .rom_bank(rom_bank),
		.timings(timings)
	);

	mem_map u_mem (
		.clk14(clk14), .rst_n(rst_n),
		.addr(addr[15:14]), .n_mreq(n_mreq),
		.ram_bank(ram_bank), .rom_bank(rom_bank),
		.n_romcs(n_romcs), .n_ramcs(n_ramcs),
		.ram_page(ram_page), .rom_page(rom_page)
	);

endmodule

`default_nettype wire

//--- test/tb_zx_ula.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_ula
	import ula_timing_pkg::*;
	import ula_bus_pkg::*;
();

	localparam logic [31:0] RAND_SEED = 32'h3bc02c32;
	localparam int FRAME_LIMIT = 2 * 2 * H_TOTAL_PENT * V_TOTAL_PENT;
	localparam int IO_LIMIT = 16;

	logic clk14 = 1'b0;
	logic rst_n;
	logic [15:0] addr;
	logic [7:0] d_in;
	logic n_rd;
	logic n_wr;
	logic n_mreq;
	logic n_iorq;
	logic n_m1;
	logic [4:0] kd;
	logic tape_in;
	logic [7:0] d_out;
	logic d_out_en;
	logic vram_rd;
	logic [SCREEN_AW-1:0] vram_addr;
	logic [7:0] vram_data;
	logic n_romcs;
	logic n_ramcs;
	logic [PAGE_W-1:0] ram_page;
	logic rom_page;
	colour_t colour;
	logic hsync;
	logic vsync;
	logic csync;
	logic n_int;
	logic beeper;
	logic tape_out;

	logic [31:0] rnd;
	logic [7:0] attr_val;
	logic [2:0] step;
	logic [2:0] border_val;
	logic [7:0] fe_val;
	logic [5:0] p7ffd_val;
	logic [7:0] read_byte;
	colour_t ink_c;
	colour_t paper_c;
	colour_t border_c;
	int cycles;
	int idx;
	int hsync_cycles;
	int csync_cycles;
	bit seen_ink;
	bit seen_paper;

	always #2 clk14 = ~clk14;

	zx_ula DUT (
		.clk14(clk14), .rst_n(rst_n),
		.addr(addr), .d_in(d_in), .n_rd(n_rd), .n_wr(n_wr),
		.n_mreq(n_mreq), .n_iorq(n_iorq), .n_m1(n_m1),
		.d_out(d_out), .d_out_en(d_out_en),
		.kd(kd), .tape_in(tape_in),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data),
		.n_romcs(n_romcs), .n_ramcs(n_ramcs), .ram_page(ram_page), .rom_page(rom_page),
		.colour(colour), .hsync(hsync), .vsync(vsync), .csync(csync),
		.n_int(n_int), .beeper(beeper), .tape_out(tape_out)
	);

	// video memory answers only a strobe, attributes from 0x1800 up and fixed bitmap below
	assign vram_data = !vram_rd ? 8'h00 :
		(vram_addr[SCREEN_AW-2:0] >= 13'h1800) ? attr_val : 8'hF0;

	function automatic int frame_period(input logic mode_128);
		// two clk14 cycles per pixel
		if (mode_128)
			return 2 * H_TOTAL_S128 * V_TOTAL_S128;
		return 2 * H_TOTAL_PENT * V_TOTAL_PENT;
	endfunction

	function automatic logic [7:0] fe_read_value(input logic [4:0] keys, input logic tape);
		return {1'b1, tape, 1'b1, keys};
	endfunction

	function automatic logic [PAGE_W-1:0] page_for_region(input logic [1:0] region,
			input logic [PAGE_W-1:0] bank);
		case (region)
			2'b01: return BANK_AT_4000;
			2'b10: return BANK_AT_8000;
			default: return bank;
		endcase
	endfunction

	function automatic colour_t colour_for(input logic [7:0] attr, input logic lit);
		logic [2:0] grb;
		colour_t c;
		grb = lit ? attr[2:0] : attr[5:3];
		c.i = attr[6] && grb != 3'd0;
		c.g = grb[2];
		c.r = grb[1];
		c.b = grb[0];
		return c;
	endfunction

	function automatic colour_t border_colour(input logic [2:0] b);
		colour_t c;
		c.i = 1'b0;
		c.g = b[2];
		c.r = b[1];
		c.b = b[0];
		return c;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_colour(input colour_t got, input colour_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_page(input logic [PAGE_W-1:0] got, input logic [PAGE_W-1:0] exp,
			input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t ns: %s got %0d expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_count(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t ns: %s got %0d expected %0d",
				$time, what, got, exp));
	endtask

	// leave any low pulse first, then count up to the next falling edge
	task automatic next_int_fall(output int count);
		count = 0;
		while (n_int !== 1'b1) begin
			@(negedge clk14);
			count++;
			if (count > FRAME_LIMIT)
				fail_run("timeout waiting for n_int to go high");
		end
		while (n_int !== 1'b0) begin
			@(negedge clk14);
			count++;
			if (count > FRAME_LIMIT)
				fail_run("timeout waiting for n_int to fall");
		end
	endtask

	task automatic int_low_width(output int count);
		count = 0;
		while (n_int === 1'b0) begin
			@(negedge clk14);
			count++;
			if (count > 2 * H_TOTAL_PENT)
				fail_run("timeout waiting for the end of the frame interrupt");
		end
	endtask

	task automatic wait_vsync_fall();
		int count;
		count = 0;
		while (vsync !== 1'b1) begin
			@(negedge clk14);
			count++;
			if (count > FRAME_LIMIT)
				fail_run("timeout waiting for vsync to rise");
		end
		while (vsync !== 1'b0) begin
			@(negedge clk14);
			count++;
			if (count > FRAME_LIMIT)
				fail_run("timeout waiting for vsync to fall");
		end
	endtask

	task automatic wait_vram_strobe();
		int count;
		count = 0;
		while (vram_rd !== 1'b1) begin
			@(negedge clk14);
			count++;
			if (count > FRAME_LIMIT)
				fail_run("timeout waiting for a video memory read");
		end
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk14);
		addr <= a;
		d_in <= d;
		n_iorq <= 1'b0;
		n_wr <= 1'b0;
		@(posedge clk14);
		n_iorq <= 1'b1;
		n_wr <= 1'b1;
	endtask

	task automatic io_read(input logic [15:0] a, output logic [7:0] data);
		int count;
		@(posedge clk14);
		addr <= a;
		n_iorq <= 1'b0;
		n_rd <= 1'b0;
		count = 0;
		while (d_out_en !== 1'b1) begin
			@(negedge clk14);
			count++;
			if (count > IO_LIMIT)
				fail_run("timeout waiting for d_out_en to rise");
		end
		data = d_out;
		@(posedge clk14);
		n_iorq <= 1'b1;
		n_rd <= 1'b1;
		count = 0;
		while (d_out_en !== 1'b0) begin
			@(negedge clk14);
			count++;
			if (count > IO_LIMIT)
				fail_run("timeout waiting for d_out_en to drop");
		end
	endtask

	task automatic check_mem_region(input logic [1:0] region, input logic [PAGE_W-1:0] bank,
			input logic rom);
		logic [31:0] offset;
		offset = $urandom;
		@(posedge clk14);
		addr <= {region, offset[13:0]};
		n_mreq <= 1'b0;
		// chip selects come out one cycle after the bus
		@(posedge clk14);
		@(negedge clk14);
		check_count(32'(n_romcs), 32'(region != 2'b00), "n_romcs");
		check_count(32'(n_ramcs), 32'(region == 2'b00), "n_ramcs");
		if (region != 2'b00)
			check_page(ram_page, page_for_region(region, bank), "ram_page");
		check_count(32'(rom_page), 32'(rom), "rom_page");
		@(posedge clk14);
		n_mreq <= 1'b1;
	endtask

	initial begin
		void'($urandom(RAND_SEED));
		rst_n = 1'b0;
		addr = '0;
		d_in = '0;
		n_rd = 1'b1;
		n_wr = 1'b1;
		n_mreq = 1'b1;
		n_iorq = 1'b1;
		n_m1 = 1'b1;
		kd = 5'h1f;
		tape_in = 1'b0;
		// flash bit clear and ink kept apart from paper
		rnd = $urandom;
		step = (rnd[5:3] == 3'd0) ? 3'd4 : rnd[5:3];
		attr_val = {1'b0, rnd[6], rnd[2:0] ^ step, rnd[2:0]};

		repeat (2) @(posedge clk14);
		rst_n <= 1'b1;
		@(posedge clk14);
		@(negedge clk14);
		check_count(32'(n_int), 32'd1, "n_int after reset");
		check_count(32'(n_romcs), 32'd1, "n_romcs after reset");
		check_count(32'(n_ramcs), 32'd1, "n_ramcs after reset");
		check_count(32'(d_out_en), 32'd0, "d_out_en after reset");
		check_count(32'(hsync), 32'd0, "hsync after reset");
		check_count(32'(vsync), 32'd0, "vsync after reset");
		check_count(32'(csync), 32'd0, "csync after reset");
		check_colour(colour, colour_t'(4'h0), "colour after reset");

		// pentagon after reset, then switch to 128K
		next_int_fall(cycles);
		next_int_fall(cycles);
		check_count(32'(cycles), 32'(frame_period(1'b0)), "pentagon frame period");
		int_low_width(cycles);
		check_count(32'(cycles), 32'd128, "n_int low width");
		io_write(16'h40FF, 8'h01);
		next_int_fall(cycles);
		next_int_fall(cycles);
		check_count(32'(cycles), 32'(frame_period(1'b1)), "128K frame period");

		rnd = $urandom;
		border_val = (rnd[2:0] == 3'd0) ? 3'd2 : rnd[2:0];
		fe_val = {3'b000, rnd[4], rnd[3], border_val};
		@(posedge clk14);
		tape_in <= rnd[8];
		io_write(16'hFFFE, fe_val);
		@(negedge clk14);
		check_count(32'(beeper), 32'(fe_val[FE_BEEPER]), "beeper");
		check_count(32'(tape_out), 32'(fe_val[FE_TAPE] ^ rnd[8]), "tape_out");
		border_c = border_colour(border_val);
		wait_vsync_fall();
		seen_ink = 1'b0;
		hsync_cycles = 0;
		csync_cycles = 0;
		repeat (2 * H_TOTAL_S128) begin
			@(negedge clk14);
			if (hsync)
				hsync_cycles++;
			if (csync)
				csync_cycles++;
			if (colour != colour_t'(4'h0)) begin
				check_colour(colour, border_c, "border colour");
				seen_ink = 1'b1;
			end
		end
		if (!seen_ink)
			fail_run("the border colour never appeared on the line after vsync");
		// one sync pulse on a line outside vsync, on both sync outputs
		check_count(32'(hsync_cycles), 32'(2 * H_SYNC_S128), "hsync width");
		check_count(32'(csync_cycles), 32'(2 * H_SYNC_S128), "csync width");

		rnd = $urandom;
		p7ffd_val = {1'b0, rnd[4], rnd[3], rnd[2:0]};
		io_write(16'h7FFD, {2'b00, p7ffd_val});
		for (idx = 0; idx < 4; idx++)
			check_mem_region(2'(idx), p7ffd_val[2:0], p7ffd_val[P7FFD_ROM]);
		// a write after the lock must not move the paging
		rnd = $urandom;
		p7ffd_val = {1'b1, rnd[4], rnd[3], rnd[2:0]};
		io_write(16'h7FFD, {2'b00, p7ffd_val});
		io_write(16'h7FFD, {2'b00, ~p7ffd_val});
		for (idx = 0; idx < 4; idx++)
			check_mem_region(2'(idx), p7ffd_val[2:0], p7ffd_val[P7FFD_ROM]);

		// first strobe of the frame opens the display line
		ink_c = colour_for(attr_val, 1'b1);
		paper_c = colour_for(attr_val, 1'b0);
		wait_vsync_fall();
		wait_vram_strobe();
		seen_ink = 1'b0;
		seen_paper = 1'b0;
		for (idx = 0; idx < 2 * (H_AREA + SCREEN_DELAY); idx++) begin
			if (vram_rd) begin
				check_count(32'(vram_addr[SCREEN_AW-1]), 32'(p7ffd_val[P7FFD_VBANK]),
					"vram_addr page bit");
				if (vram_addr[SCREEN_AW-2:0] >= 13'h1B00)
					fail_run($sformatf("mismatch at %0t ns: vram_addr %h lies outside the screen area",
						$time, vram_addr));
			end
			if (idx >= 2 * SCREEN_DELAY + 2 && idx < 2 * (H_AREA + SCREEN_DELAY) - 2) begin
				if (colour == ink_c) begin
					seen_ink = 1'b1;
				end else begin
					check_colour(colour, paper_c, "display colour");
					seen_paper = 1'b1;
				end
			end
			@(negedge clk14);
		end
		if (!(seen_ink && seen_paper))
			fail_run("ink and paper did not both appear on the first display line");

		rnd = $urandom;
		@(posedge clk14);
		kd <= rnd[4:0];
		tape_in <= rnd[5];
		io_read(16'h00FE, read_byte);
		check_byte(read_byte, fe_read_value(rnd[4:0], rnd[5]), "port FE read");

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
